//--- verilog/msr_pkg.sv
/* MSR unit definitions
   Address map, PSR layout, CPUID fields and exception vectors */
package msr_pkg;

   localparam int DW         = 32;
   localparam int MSR_ADDR_W = 4;
   localparam int PSR_DW     = 10;

   // MSR address map with 6 to 15 unmapped
   localparam logic [MSR_ADDR_W-1:0] MSR_PSR    = 4'd0;
   localparam logic [MSR_ADDR_W-1:0] MSR_CPUID  = 4'd1;
   localparam logic [MSR_ADDR_W-1:0] MSR_EPSR   = 4'd2;
   localparam logic [MSR_ADDR_W-1:0] MSR_EPC    = 4'd3;
   localparam logic [MSR_ADDR_W-1:0] MSR_ELSA   = 4'd4;
   localparam logic [MSR_ADDR_W-1:0] MSR_COREID = 4'd5;

   // PSR flag positions
   localparam int PSR_CC   = 0;
   localparam int PSR_RM   = 4;
   localparam int PSR_IRE  = 5;
   localparam int PSR_IMME = 6;
   localparam int PSR_DMME = 7;

   // CPUID fields
   localparam logic [7:0] CPUID_VER   = 8'd1;
   localparam logic [9:0] CPUID_REV   = 10'd0;
   localparam logic       CPUID_FIMM  = 1'b1;
   localparam logic       CPUID_FDMM  = 1'b0;
   localparam logic       CPUID_FICA  = 1'b0;
   localparam logic       CPUID_FDCA  = 1'b0;
   localparam logic       CPUID_FDBG  = 1'b0;
   localparam logic       CPUID_FFPU  = 1'b0;
   localparam logic       CPUID_FIRQC = 1'b0;
   localparam logic       CPUID_FTSC  = 1'b0;

   // Version in the low byte and feature flags above the revision
   localparam logic [DW-1:0] CPUID_WORD = {6'b0,
                                           CPUID_FTSC, CPUID_FIRQC, CPUID_FFPU, CPUID_FDBG,
                                           CPUID_FDCA, CPUID_FICA, CPUID_FDMM, CPUID_FIMM,
                                           CPUID_REV, CPUID_VER};

   localparam logic [DW-1:0] COREID_WORD = '0;

   // Exception causes
   localparam int EXC_CAUSE_W = 3;
   localparam logic [EXC_CAUSE_W-1:0] EXC_SYSCALL = 3'd1;
   localparam logic [EXC_CAUSE_W-1:0] EXC_IRQ     = 3'd2;
   localparam logic [EXC_CAUSE_W-1:0] EXC_IPF     = 3'd3;
   localparam logic [EXC_CAUSE_W-1:0] EXC_DPF     = 3'd4;
   localparam logic [EXC_CAUSE_W-1:0] EXC_ILL     = 3'd5;

   // Vector = base + cause * stride
   localparam logic [DW-1:0] EXC_VECTOR_BASE   = 32'h0000_0100;
   localparam int            EXC_VECTOR_STRIDE = 16;

   // PSR layout inside a full MSR word
   typedef struct packed {
      logic [21:0] unused;
      logic [1:0]  rsv_hi;
      logic        dmme;
      logic        imme;
      logic        ire;
      logic        rm;
      logic [2:0]  rsv_lo;
      logic        cc;
   } psr_view_t;

   typedef union packed {
      logic [DW-1:0] raw;
      psr_view_t     psr;
   } msr_word_u;

endpackage

//--- verilog/msr_access.sv
/* MSR access port
   Write decode into per-register enables and the bypassed read mux */
`timescale 1ns/100ps

module msr_access import msr_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [MSR_ADDR_W-1:0] msr_addr,
   input  logic [DW-1:0]         msr_wdat,
   input  logic                  msr_we,
   output logic [DW-1:0]         msr_rdat,
   // ALU condition flag
   input  logic                  alu_cc_nxt,
   input  logic                  alu_cc_we,
   // Bypassed state from the PSR block
   input  logic [PSR_DW-1:0]     psr,
   input  logic [PSR_DW-1:0]     epsr,
   input  logic [DW-1:0]         epc,
   input  logic [DW-1:0]         elsa,
   // Per-register writes
   output logic                  cc_nxt,
   output logic                  cc_we,
   output logic                  rm_nxt,
   output logic                  rm_we,
   output logic                  ire_nxt,
   output logic                  ire_we,
   output logic                  imme_nxt,
   output logic                  imme_we,
   output logic                  dmme_nxt,
   output logic                  dmme_we,
   output logic [PSR_DW-1:0]     epsr_nxt,
   output logic                  epsr_we,
   output logic [DW-1:0]         epc_nxt,
   output logic                  epc_we,
   output logic [DW-1:0]         elsa_nxt,
   output logic                  elsa_we
);

   msr_word_u wr;
   logic      psr_sel;

   // Keep only the defined flags of a written PSR word
   function automatic logic [PSR_DW-1:0] psr_flags(input msr_word_u w);
      logic [PSR_DW-1:0] f;
      f           = '0;
      f[PSR_CC]   = w.psr.cc;
      f[PSR_RM]   = w.psr.rm;
      f[PSR_IRE]  = w.psr.ire;
      f[PSR_IMME] = w.psr.imme;
      f[PSR_DMME] = w.psr.dmme;
      return f;
   endfunction

   assign wr.raw  = msr_wdat;
   assign psr_sel = msr_we && (msr_addr == MSR_PSR);

   // mtmsr to PSR beats the ALU in the same cycle
   assign cc_we  = psr_sel | alu_cc_we;
   assign cc_nxt = psr_sel ? wr.psr.cc : alu_cc_nxt;

   assign rm_we    = psr_sel;
   assign rm_nxt   = wr.psr.rm;
   assign ire_we   = psr_sel;
   assign ire_nxt  = wr.psr.ire;
   assign imme_we  = psr_sel;
   assign imme_nxt = wr.psr.imme;
   assign dmme_we  = psr_sel;
   assign dmme_nxt = wr.psr.dmme;

   assign epsr_we  = msr_we && (msr_addr == MSR_EPSR);
   assign epsr_nxt = psr_flags(wr);
   assign epc_we   = msr_we && (msr_addr == MSR_EPC);
   assign epc_nxt  = msr_wdat;
   assign elsa_we  = msr_we && (msr_addr == MSR_ELSA);
   assign elsa_nxt = msr_wdat;

   // CPUID, COREID and unmapped reads are constants
   always_comb begin
      case (msr_addr)
         MSR_PSR:    msr_rdat = DW'(psr);
         MSR_CPUID:  msr_rdat = CPUID_WORD;
         MSR_EPSR:   msr_rdat = DW'(epsr);
         MSR_EPC:    msr_rdat = epc;
         MSR_ELSA:   msr_rdat = elsa;
         MSR_COREID: msr_rdat = COREID_WORD;
         default:    msr_rdat = '0;
      endcase
   end

   a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      msr_we |-> !$isunknown(msr_addr));

endmodule

//--- verilog/msr_psr.sv
/* PSR flags, EPSR, EPC and ELSA registers
   Exception load and restore with same-cycle bypass on every output */
`timescale 1ns/100ps

module msr_psr import msr_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   // Software and ALU writes
   input  logic              cc_nxt,
   input  logic              cc_we,
   input  logic              rm_nxt,
   input  logic              rm_we,
   input  logic              ire_nxt,
   input  logic              ire_we,
   input  logic              imme_nxt,
   input  logic              imme_we,
   input  logic              dmme_nxt,
   input  logic              dmme_we,
   input  logic [PSR_DW-1:0] epsr_nxt,
   input  logic              epsr_we,
   input  logic [DW-1:0]     epc_nxt,
   input  logic              epc_we,
   input  logic [DW-1:0]     elsa_nxt,
   input  logic              elsa_we,
   // Exception sequencer
   input  logic              exc_ent,
   input  logic              exc_ret,
   input  logic [DW-1:0]     ent_pc,
   input  logic [DW-1:0]     ent_lsa,
   // Bypassed state
   output logic [PSR_DW-1:0] psr,
   output logic [PSR_DW-1:0] psr_nold,
   output logic [PSR_DW-1:0] epsr,
   output logic [DW-1:0]     epc,
   output logic [DW-1:0]     elsa,
   output logic              psr_cc,
   output logic              psr_rm,
   output logic              psr_ire,
   output logic              psr_imme,
   output logic              psr_dmme
);

   logic              cc_r;
   logic              rm_r;
   logic              ire_r;
   logic              imme_r;
   logic              dmme_r;
   logic [PSR_DW-1:0] epsr_r;
   logic [DW-1:0]     epc_r;
   logic [DW-1:0]     elsa_r;

   logic              psr_ld;
   logic              cc_en, rm_en, ire_en, imme_en, dmme_en;
   logic              cc_d, rm_d, ire_d, imme_d, dmme_d;
   logic              cc_nold, rm_nold, ire_nold, imme_nold, dmme_nold;
   logic              epsr_en, epc_en, elsa_en;
   logic [PSR_DW-1:0] epsr_d;
   logic [DW-1:0]     epc_d;
   logic [DW-1:0]     elsa_d;

   // Entry and return both override a software write to the same flag
   assign psr_ld = exc_ent | exc_ret;

   // cc is kept on entry, so only a return loads it
   assign cc_en   = cc_we | exc_ret;
   assign rm_en   = rm_we | psr_ld;
   assign ire_en  = ire_we | psr_ld;
   assign imme_en = imme_we | psr_ld;
   assign dmme_en = dmme_we | psr_ld;

   // Entry sets supervisor mode with interrupts and both MMUs off
   assign cc_d   = exc_ret ? epsr[PSR_CC] : cc_nxt;
   assign rm_d   = exc_ent ? 1'b1 : (exc_ret ? epsr[PSR_RM] : rm_nxt);
   assign ire_d  = exc_ent ? 1'b0 : (exc_ret ? epsr[PSR_IRE] : ire_nxt);
   assign imme_d = exc_ent ? 1'b0 : (exc_ret ? epsr[PSR_IMME] : imme_nxt);
   assign dmme_d = exc_ent ? 1'b0 : (exc_ret ? epsr[PSR_DMME] : dmme_nxt);

   // Pre-entry view with software writes only
   assign cc_nold   = cc_we ? cc_nxt : cc_r;
   assign rm_nold   = rm_we ? rm_nxt : rm_r;
   assign ire_nold  = ire_we ? ire_nxt : ire_r;
   assign imme_nold = imme_we ? imme_nxt : imme_r;
   assign dmme_nold = dmme_we ? dmme_nxt : dmme_r;

   // Saved state wins over a software write in an entry cycle
   assign epsr_en = epsr_we | exc_ent;
   assign epc_en  = epc_we | exc_ent;
   assign elsa_en = elsa_we | exc_ent;
   assign epsr_d  = exc_ent ? psr_nold : epsr_nxt;
   assign epc_d   = exc_ent ? ent_pc : epc_nxt;
   assign elsa_d  = exc_ent ? ent_lsa : elsa_nxt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cc_r   <= 1'b0;
         rm_r   <= 1'b1;
         ire_r  <= 1'b0;
         imme_r <= 1'b0;
         dmme_r <= 1'b0;
      end else begin
         if (cc_en)
            cc_r <= cc_d;
         if (rm_en)
            rm_r <= rm_d;
         if (ire_en)
            ire_r <= ire_d;
         if (imme_en)
            imme_r <= imme_d;
         if (dmme_en)
            dmme_r <= dmme_d;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epsr_r <= '0;
         epc_r  <= '0;
         elsa_r <= '0;
      end else begin
         if (epsr_en)
            epsr_r <= epsr_d;
         if (epc_en)
            epc_r <= epc_d;
         if (elsa_en)
            elsa_r <= elsa_d;
      end
   end

   // Bypass
   assign psr_cc   = cc_en ? cc_d : cc_r;
   assign psr_rm   = rm_en ? rm_d : rm_r;
   assign psr_ire  = ire_en ? ire_d : ire_r;
   assign psr_imme = imme_en ? imme_d : imme_r;
   assign psr_dmme = dmme_en ? dmme_d : dmme_r;

   assign epsr = epsr_en ? epsr_d : epsr_r;
   assign epc  = epc_en ? epc_d : epc_r;
   assign elsa = elsa_en ? elsa_d : elsa_r;

   // Reserved bits stay zero
   always_comb begin
      psr                = '0;
      psr[PSR_CC]        = psr_cc;
      psr[PSR_RM]        = psr_rm;
      psr[PSR_IRE]       = psr_ire;
      psr[PSR_IMME]      = psr_imme;
      psr[PSR_DMME]      = psr_dmme;
      psr_nold           = '0;
      psr_nold[PSR_CC]   = cc_nold;
      psr_nold[PSR_RM]   = rm_nold;
      psr_nold[PSR_IRE]  = ire_nold;
      psr_nold[PSR_IMME] = imme_nold;
      psr_nold[PSR_DMME] = dmme_nold;
   end

   // Sequencer priority keeps entry and return apart
   a_ent_ret_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(exc_ent && exc_ret));

endmodule

//--- verilog/exc_ctrl.sv
/* Exception sequencer
   Entry and return strobes, interrupt gating, vectors and fetch redirect */
`timescale 1ns/100ps

module exc_ctrl import msr_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   // Exception request
   input  logic                   exc_valid,
   input  logic [EXC_CAUSE_W-1:0] exc_cause,
   input  logic [DW-1:0]          exc_pc,
   input  logic [DW-1:0]          exc_lsa,
   input  logic                   eret,
   input  logic                   irq,
   // State from the PSR block
   input  logic                   psr_ire,
   input  logic [DW-1:0]          epc,
   // Strobes and saved values to the PSR block
   output logic                   exc_ent,
   output logic                   exc_ret,
   output logic [DW-1:0]          ent_pc,
   output logic [DW-1:0]          ent_lsa,
   // Fetch redirect
   output logic                   redirect_valid,
   output logic [DW-1:0]          redirect_pc
);

   logic                   irq_take;
   logic [EXC_CAUSE_W-1:0] ent_cause;
   logic [DW-1:0]          vector;

   // A synchronous exception hides a pending interrupt this cycle
   assign irq_take = irq & psr_ire & ~exc_valid;

   // An accepted interrupt is an exception and beats eret
   assign exc_ent = exc_valid | irq_take;
   assign exc_ret = eret & ~exc_ent;

   assign ent_cause = exc_valid ? exc_cause : EXC_IRQ;
   assign ent_pc    = exc_pc;
   assign ent_lsa   = exc_valid ? exc_lsa : '0;

   assign vector = EXC_VECTOR_BASE + DW'(ent_cause) * DW'(EXC_VECTOR_STRIDE);

   // One-cycle redirect after each strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         redirect_valid <= 1'b0;
      end else begin
         redirect_valid <= exc_ent | exc_ret;
      end
   end

   // Return target is the EPC seen in the return cycle
   always_ff @(posedge clk) begin
      if (exc_ent | exc_ret) begin
         redirect_pc <= exc_ent ? vector : epc;
      end
   end

   // Only defined causes reach the vector table
   a_cause_valid: assert property (@(posedge clk) disable iff (!rst_n)
      exc_valid |-> (exc_cause >= EXC_SYSCALL && exc_cause <= EXC_ILL));

endmodule

//--- verilog/msr_unit.sv
/* MSR unit top level
   Joins the access port, the PSR registers and the exception sequencer */
`timescale 1ns/100ps

module msr_unit import msr_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   // Software MSR access
   input  logic [MSR_ADDR_W-1:0]  msr_addr,
   input  logic [DW-1:0]          msr_wdat,
   input  logic                   msr_we,
   output logic [DW-1:0]          msr_rdat,
   // ALU condition flag
   input  logic                   alu_cc_nxt,
   input  logic                   alu_cc_we,
   // Exceptions
   input  logic                   exc_valid,
   input  logic [EXC_CAUSE_W-1:0] exc_cause,
   input  logic [DW-1:0]          exc_pc,
   input  logic [DW-1:0]          exc_lsa,
   input  logic                   eret,
   input  logic                   irq,
   // Fetch redirect
   output logic                   redirect_valid,
   output logic [DW-1:0]          redirect_pc,
   // Flags to the pipeline
   output logic                   psr_rm,
   output logic                   psr_ire,
   output logic                   psr_imme,
   output logic                   psr_dmme,
   output logic                   psr_cc
);

   logic              cc_nxt, cc_we, rm_nxt, rm_we, ire_nxt, ire_we;
   logic              imme_nxt, imme_we, dmme_nxt, dmme_we;
   logic [PSR_DW-1:0] epsr_nxt;
   logic              epsr_we;
   logic [DW-1:0]     epc_nxt;
   logic              epc_we;
   logic [DW-1:0]     elsa_nxt;
   logic              elsa_we;
   logic [PSR_DW-1:0] psr, psr_nold, epsr;
   logic [DW-1:0]     epc, elsa;
   logic              exc_ent, exc_ret;
   logic [DW-1:0]     ent_pc, ent_lsa;

   msr_access u_access (
      .clk, .rst_n, .msr_addr, .msr_wdat, .msr_we, .msr_rdat,
      .alu_cc_nxt, .alu_cc_we, .psr, .epsr, .epc, .elsa,
      .cc_nxt, .cc_we, .rm_nxt, .rm_we, .ire_nxt, .ire_we,
      .imme_nxt, .imme_we, .dmme_nxt, .dmme_we,
      .epsr_nxt, .epsr_we, .epc_nxt, .epc_we, .elsa_nxt, .elsa_we
   );

   msr_psr u_psr (
      .clk, .rst_n,
      .cc_nxt, .cc_we, .rm_nxt, .rm_we, .ire_nxt, .ire_we,
      .imme_nxt, .imme_we, .dmme_nxt, .dmme_we,
      .epsr_nxt, .epsr_we, .epc_nxt, .epc_we, .elsa_nxt, .elsa_we,
      .exc_ent, .exc_ret, .ent_pc, .ent_lsa,
      .psr, .psr_nold, .epsr, .epc, .elsa,
      .psr_cc, .psr_rm, .psr_ire, .psr_imme, .psr_dmme
   );

   // Interrupt gate uses the pre-entry ire because the bypassed one depends on exc_ent
   exc_ctrl u_exc (
      .clk, .rst_n, .exc_valid, .exc_cause, .exc_pc, .exc_lsa, .eret, .irq,
      .psr_ire        (psr_nold[PSR_IRE]),
      .epc, .exc_ent, .exc_ret, .ent_pc, .ent_lsa,
      .redirect_valid, .redirect_pc
   );

endmodule

//--- bench/msr_model.svh
/* MSR unit reference model
   Model state, next-state and read predictions, LFSR source and value check */
`ifndef MSR_MODEL_SVH
`define MSR_MODEL_SVH

typedef struct {
   logic              cc;
   logic              rm;
   logic              ire;
   logic              imme;
   logic              dmme;
   logic [PSR_DW-1:0] epsr;
   logic [DW-1:0]     epc;
   logic [DW-1:0]     elsa;
   logic              rv;
   logic [DW-1:0]     rpc;
} model_t;

localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

model_t      mdl;
logic [31:0] lfsr_state = 32'd91;
int          errors = 0;
int          checks = 0;

function automatic model_t reset_model();
   model_t s;
   s = '{cc: 1'b0, rm: 1'b1, ire: 1'b0, imme: 1'b0, dmme: 1'b0,
         epsr: '0, epc: '0, elsa: '0, rv: 1'b0, rpc: '0};
   return s;
endfunction

// One step per bit with the newest bit in the LSB
function automatic logic [DW-1:0] rand_bits(input int n);
   logic [DW-1:0] r;
   logic          b;
   r = '0;
   for (int i = 0; i < n; i++) begin
      b          = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ LFSR_POLY;
      r = {r[DW-2:0], b};
   end
   return r;
endfunction

function automatic logic [PSR_DW-1:0] flags_of(input msr_word_u w);
   logic [PSR_DW-1:0] f;
   f           = '0;
   f[PSR_CC]   = w.psr.cc;
   f[PSR_RM]   = w.psr.rm;
   f[PSR_IRE]  = w.psr.ire;
   f[PSR_IMME] = w.psr.imme;
   f[PSR_DMME] = w.psr.dmme;
   return f;
endfunction

// Walk the vector table one stride per cause value
function automatic logic [DW-1:0] vector_of(input logic [EXC_CAUSE_W-1:0] c);
   logic [DW-1:0] v;
   v = EXC_VECTOR_BASE;
   for (int i = 0; i < c; i++)
      v = v + EXC_VECTOR_STRIDE;
   return v;
endfunction

// Next state from the current inputs, which is also the bypassed view
function automatic model_t step_model(input model_t s);
   model_t                 n;
   msr_word_u              w;
   logic                   sw_psr;
   logic [PSR_DW-1:0]      pre;
   logic [PSR_DW-1:0]      epsr_b;
   logic [DW-1:0]          epc_b;
   logic [DW-1:0]          elsa_b;
   logic                   ent;
   logic [EXC_CAUSE_W-1:0] cause;
   w.raw  = msr_wdat;
   sw_psr = msr_we && msr_addr == MSR_PSR;
   // Flags as software and the ALU leave them before any exception
   pre           = '0;
   pre[PSR_CC]   = sw_psr ? w.psr.cc : (alu_cc_we ? alu_cc_nxt : s.cc);
   pre[PSR_RM]   = sw_psr ? w.psr.rm : s.rm;
   pre[PSR_IRE]  = sw_psr ? w.psr.ire : s.ire;
   pre[PSR_IMME] = sw_psr ? w.psr.imme : s.imme;
   pre[PSR_DMME] = sw_psr ? w.psr.dmme : s.dmme;
   epsr_b = (msr_we && msr_addr == MSR_EPSR) ? flags_of(w) : s.epsr;
   epc_b  = (msr_we && msr_addr == MSR_EPC) ? msr_wdat : s.epc;
   elsa_b = (msr_we && msr_addr == MSR_ELSA) ? msr_wdat : s.elsa;
   ent    = exc_valid || (irq && pre[PSR_IRE]);
   cause  = exc_valid ? exc_cause : EXC_IRQ;
   n      = s;
   n.cc   = pre[PSR_CC];
   n.rm   = pre[PSR_RM];
   n.ire  = pre[PSR_IRE];
   n.imme = pre[PSR_IMME];
   n.dmme = pre[PSR_DMME];
   n.epsr = epsr_b;
   n.epc  = epc_b;
   n.elsa = elsa_b;
   n.rv   = 1'b0;
   if (ent) begin
      n.rm   = 1'b1;
      n.ire  = 1'b0;
      n.imme = 1'b0;
      n.dmme = 1'b0;
      n.epsr = pre;
      n.epc  = exc_pc;
      n.elsa = exc_valid ? exc_lsa : '0;
      n.rv   = 1'b1;
      n.rpc  = vector_of(cause);
   end else if (eret) begin
      n.cc   = epsr_b[PSR_CC];
      n.rm   = epsr_b[PSR_RM];
      n.ire  = epsr_b[PSR_IRE];
      n.imme = epsr_b[PSR_IMME];
      n.dmme = epsr_b[PSR_DMME];
      n.rv   = 1'b1;
      n.rpc  = epc_b;
   end
   return n;
endfunction

function automatic logic [DW-1:0] read_ref(input model_t n, input logic [MSR_ADDR_W-1:0] a);
   msr_word_u w;
   w.raw      = '0;
   w.psr.cc   = n.cc;
   w.psr.rm   = n.rm;
   w.psr.ire  = n.ire;
   w.psr.imme = n.imme;
   w.psr.dmme = n.dmme;
   case (a)
      MSR_PSR:    return w.raw;
      MSR_CPUID:  return CPUID_WORD;
      MSR_EPSR:   return DW'(n.epsr);
      MSR_EPC:    return n.epc;
      MSR_ELSA:   return n.elsa;
      MSR_COREID: return COREID_WORD;
      default:    return '0;
   endcase
endfunction

task automatic check(input string name, input logic [DW-1:0] exp, input logic [DW-1:0] act);
   checks++;
   if (act !== exp) begin
      errors++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
   end
endtask

`endif

//--- bench/msr_tb.sv
/* Testbench for the MSR unit
   Directed and random MSR traffic compared each cycle with a reference model */
`timescale 1ns/100ps

module msr_tb import msr_pkg::*; ();

   localparam int CLK_NS      = 100;
   localparam int N_WR        = 40;
   localparam int N_CC        = 40;
   localparam int N_ENT       = 20;
   localparam int N_IRQ       = 10;
   localparam int N_MIX       = 400;
   localparam int TOTAL_CYC   = 4 + 24 + 2 * N_WR + N_CC + 3 * N_ENT + 8 * N_IRQ + N_MIX + 4;
   localparam int WATCHDOG_NS = (TOTAL_CYC + 50) * CLK_NS;

   logic                   clk;
   logic                   rst_n;
   logic [MSR_ADDR_W-1:0]  msr_addr;
   logic [DW-1:0]          msr_wdat;
   logic                   msr_we;
   logic [DW-1:0]          msr_rdat;
   logic                   alu_cc_nxt;
   logic                   alu_cc_we;
   logic                   exc_valid;
   logic [EXC_CAUSE_W-1:0] exc_cause;
   logic [DW-1:0]          exc_pc;
   logic [DW-1:0]          exc_lsa;
   logic                   eret;
   logic                   irq;
   logic                   redirect_valid;
   logic [DW-1:0]          redirect_pc;
   logic                   psr_rm;
   logic                   psr_ire;
   logic                   psr_imme;
   logic                   psr_dmme;
   logic                   psr_cc;
   int                     test_num = 0;
   int                     err_base = 0;
   int                     chk_base = 0;

`include "msr_model.svh"

   msr_unit dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Compare at the falling edge, then advance the model
   always @(negedge clk) begin
      model_t nx;
      if (rst_n !== 1'b1) begin
         mdl = reset_model();
      end else begin
         nx = step_model(mdl);
         check("msr_rdat", read_ref(nx, msr_addr), msr_rdat);
         check("psr_cc", nx.cc, psr_cc);
         check("psr_rm", nx.rm, psr_rm);
         check("psr_ire", nx.ire, psr_ire);
         check("psr_imme", nx.imme, psr_imme);
         check("psr_dmme", nx.dmme, psr_dmme);
         check("redirect_valid", mdl.rv, redirect_valid);
         if (mdl.rv)
            check("redirect_pc", mdl.rpc, redirect_pc);
         mdl = nx;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("FAIL: see errors above");
      $finish;
   end

   // New cycle with all strobes low
   task automatic start_cycle();
      @(posedge clk);
      msr_we    <= 1'b0;
      alu_cc_we <= 1'b0;
      exc_valid <= 1'b0;
      eret      <= 1'b0;
      irq       <= 1'b0;
   endtask

   task automatic drive_write(input logic [MSR_ADDR_W-1:0] a, input logic [DW-1:0] d);
      msr_addr <= a;
      msr_wdat <= d;
      msr_we   <= 1'b1;
   endtask

   task automatic drive_exc(input logic [EXC_CAUSE_W-1:0] c);
      exc_valid <= 1'b1;
      exc_cause <= c;
      exc_pc    <= rand_bits(32);
      exc_lsa   <= rand_bits(32);
   endtask

   task automatic report_test(input string name);
      @(negedge clk);
      #1;
      test_num++;
      $display("test %0d %s: %0d checks, %0d errors", test_num, name,
               checks - chk_base, errors - err_base);
      chk_base = checks;
      err_base = errors;
   endtask

   function automatic logic [MSR_ADDR_W-1:0] rw_addr(input logic [1:0] sel);
      case (sel)
         2'd0:    return MSR_PSR;
         2'd1:    return MSR_EPSR;
         2'd2:    return MSR_EPC;
         default: return MSR_ELSA;
      endcase
   endfunction

   function automatic logic [EXC_CAUSE_W-1:0] rand_cause();
      return EXC_CAUSE_W'(1 + rand_bits(8) % 5);
   endfunction

   initial begin
      logic [MSR_ADDR_W-1:0] a;
      rst_n      = 1'b0;
      msr_addr   = '0;
      msr_wdat   = '0;
      msr_we     = 1'b0;
      alu_cc_nxt = 1'b0;
      alu_cc_we  = 1'b0;
      exc_valid  = 1'b0;
      exc_cause  = '0;
      exc_pc     = '0;
      exc_lsa    = '0;
      eret       = 1'b0;
      irq        = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Full address sweep, then writes to read-only and unmapped words
      for (int i = 0; i < 16; i++) begin
         start_cycle();
         msr_addr <= MSR_ADDR_W'(i);
      end
      for (int i = 0; i < 8; i++) begin
         start_cycle();
         a = (i < 2) ? MSR_CPUID : ((i < 4) ? MSR_COREID : MSR_ADDR_W'(6 + rand_bits(3)));
         drive_write(a, rand_bits(32));
      end
      report_test("reset and read-only");

      for (int i = 0; i < N_WR; i++) begin
         a = rw_addr(2'(rand_bits(2)));
         start_cycle();
         drive_write(a, rand_bits(32));
         start_cycle();
         msr_addr <= a;
      end
      report_test("write and bypass");

      for (int i = 0; i < N_CC; i++) begin
         start_cycle();
         msr_addr   <= MSR_PSR;
         alu_cc_we  <= 1'(rand_bits(1));
         alu_cc_nxt <= 1'(rand_bits(1));
         if (rand_bits(2) == 0)
            drive_write(MSR_PSR, rand_bits(32));
      end
      report_test("condition flag");

      for (int i = 0; i < N_ENT; i++) begin
         start_cycle();
         drive_write(MSR_PSR, rand_bits(32));
         start_cycle();
         msr_addr <= MSR_EPSR;
         drive_exc(rand_cause());
         start_cycle();
         msr_addr <= (i % 2) ? MSR_EPC : MSR_ELSA;
      end
      report_test("exception entry");

      // irq held off by ire, then taken, then eret
      for (int i = 0; i < N_IRQ; i++) begin
         start_cycle();
         drive_write(MSR_PSR, rand_bits(32) & ~(32'h1 << PSR_IRE));
         start_cycle();
         irq    <= 1'b1;
         exc_pc <= rand_bits(32);
         start_cycle();
         irq      <= 1'b1;
         msr_addr <= MSR_EPSR;
         start_cycle();
         drive_write(MSR_PSR, rand_bits(32) | (32'h1 << PSR_IRE));
         start_cycle();
         irq    <= 1'b1;
         exc_pc <= rand_bits(32);
         start_cycle();
         msr_addr <= MSR_EPC;
         start_cycle();
         eret     <= 1'b1;
         msr_addr <= MSR_PSR;
         start_cycle();
      end
      report_test("interrupt gating and return");

      for (int i = 0; i < N_MIX; i++) begin
         start_cycle();
         msr_addr   <= MSR_ADDR_W'(rand_bits(3));
         msr_wdat   <= rand_bits(32);
         msr_we     <= 1'(rand_bits(1));
         alu_cc_we  <= 1'(rand_bits(1));
         alu_cc_nxt <= 1'(rand_bits(1));
         if (rand_bits(3) == 0)
            drive_exc(rand_cause());
         eret <= (rand_bits(2) == 0);
         irq  <= 1'(rand_bits(1));
      end
      repeat (4) start_cycle();
      report_test("random mix");

      $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- compile.f
+incdir+bench
verilog/msr_pkg.sv
verilog/msr_access.sv
verilog/msr_psr.sv
verilog/exc_ctrl.sv
verilog/msr_unit.sv
bench/msr_tb.sv
